// File: rv32i_types_pkg.sv
package rv32i_types_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = $clog2(NUM_REGS);

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq = 3'b000, bne = 3'b001, blt = 3'b100,
        bge = 3'b101, bltu = 3'b110, bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb = 3'b000, lh = 3'b001, lw = 3'b010, lbu = 3'b100, lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000, sh = 3'b001, sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add = 3'b000, sll = 3'b001, slt = 3'b010, sltu = 3'b011,
        axor = 3'b100, sr = 3'b101, aor = 3'b110, aand = 3'b111
    } arith_funct3_t;

    // lines up with arith funct3 except sra/sub in the slt slots
    typedef enum logic [2:0] {
        alu_add = 3'b000, alu_sll = 3'b001, alu_sra = 3'b010, alu_sub = 3'b011,
        alu_xor = 3'b100, alu_srl = 3'b101, alu_or = 3'b110, alu_and = 3'b111
    } alu_ops;

    typedef enum logic [1:0] {
        pcmux_pc_plus4, pcmux_alu_out, pcmux_alu_mod2
    } pcmux_sel_t;

    typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_b_imm,
        alumux2_s_imm, alumux2_j_imm, alumux2_rs2_out
    } alumux2_sel_t;

    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;

    typedef enum logic [3:0] {
        regfilemux_alu_out, regfilemux_br_en, regfilemux_u_imm,
        regfilemux_lw, regfilemux_pc_plus4, regfilemux_lb,
        regfilemux_lbu, regfilemux_lh, regfilemux_lhu
    } regfilemux_sel_t;

    typedef enum logic {marmux_pc_out, marmux_alu_out} marmux_sel_t;

    typedef struct packed {
        rv32i_opcode     opcode;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        logic            mem_read;
        logic            mem_write;
        logic            load_regfile;
        pcmux_sel_t      pcmux_sel;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        regfilemux_sel_t regfilemux_sel;
        cmpmux_sel_t     cmpmux_sel;
        marmux_sel_t     marmux_sel;
        alu_ops          aluop;
        branch_funct3_t  cmpop;
        logic [3:0]      mem_byte_en;
    } rv32i_control_word;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        rv32i_control_word ctrl;
        logic [XLEN-1:0]   rs1_val;
        logic [XLEN-1:0]   rs2_val;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   i_imm;
        logic [XLEN-1:0]   s_imm;
        logic [XLEN-1:0]   b_imm;
        logic [XLEN-1:0]   u_imm;
        logic [XLEN-1:0]   j_imm;
    } id_ex_t;

    // writeback report, doubles as the regfile write port
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        logic              taken;
        logic [XLEN-1:0]   target;
    } wb_t;

    typedef struct packed {
        logic            read;
        logic            write;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0]      byte_en;
    } mem_req_t;

endpackage

// File: control_rom.sv
module control_rom
    import rv32i_types_pkg::*;
(
    input  rv32i_opcode       opcode,
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    output rv32i_control_word ctrl
);

    load_funct3_t  load_funct3;
    store_funct3_t store_funct3;
    arith_funct3_t arith_funct3;

    assign load_funct3  = load_funct3_t'(funct3);
    assign store_funct3 = store_funct3_t'(funct3);
    assign arith_funct3 = arith_funct3_t'(funct3);

    always_comb begin
        // defaults, overridden per opcode below
        ctrl.opcode         = opcode;
        ctrl.funct3         = funct3;
        ctrl.funct7         = funct7;
        ctrl.mem_read       = 1'b0;
        ctrl.mem_write      = 1'b0;
        ctrl.load_regfile   = 1'b0;
        ctrl.pcmux_sel      = pcmux_pc_plus4;
        ctrl.alumux1_sel    = alumux1_rs1_out;
        ctrl.alumux2_sel    = alumux2_i_imm;
        ctrl.regfilemux_sel = regfilemux_alu_out;
        ctrl.cmpmux_sel     = cmpmux_rs2_out;
        ctrl.marmux_sel     = marmux_pc_out;
        ctrl.aluop          = alu_add;
        ctrl.cmpop          = beq;
        ctrl.mem_byte_en    = 4'b1111;

        case (opcode)
            op_lui: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc: begin
                ctrl.alumux1_sel  = alumux1_pc_out;
                ctrl.alumux2_sel  = alumux2_u_imm;
                ctrl.load_regfile = 1'b1;
            end
            op_jal: begin
                ctrl.alumux1_sel    = alumux1_pc_out;
                ctrl.alumux2_sel    = alumux2_j_imm;
                ctrl.pcmux_sel      = pcmux_alu_out;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            op_jalr: begin
                ctrl.pcmux_sel      = pcmux_alu_mod2; // target lsb dropped
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            op_br: begin
                ctrl.alumux1_sel = alumux1_pc_out;
                ctrl.alumux2_sel = alumux2_b_imm;
                ctrl.cmpop       = branch_funct3_t'(funct3);
            end
            op_load: begin
                ctrl.marmux_sel   = marmux_alu_out;
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                case (load_funct3)
                    lb:      ctrl.regfilemux_sel = regfilemux_lb;
                    lbu:     ctrl.regfilemux_sel = regfilemux_lbu;
                    lh:      ctrl.regfilemux_sel = regfilemux_lh;
                    lhu:     ctrl.regfilemux_sel = regfilemux_lhu;
                    default: ctrl.regfilemux_sel = regfilemux_lw;
                endcase
            end
            op_store: begin
                ctrl.marmux_sel  = marmux_alu_out;
                ctrl.alumux2_sel = alumux2_s_imm;
                ctrl.mem_write   = 1'b1;
                case (store_funct3)
                    sb:      ctrl.mem_byte_en = 4'b0001; // not shifted by addr
                    sh:      ctrl.mem_byte_en = 4'b0011;
                    default: ctrl.mem_byte_en = 4'b1111;
                endcase
            end
            op_imm, op_reg: begin
                ctrl.load_regfile = 1'b1;
                if (opcode == op_reg) begin
                    ctrl.alumux2_sel = alumux2_rs2_out;
                end
                case (arith_funct3)
                    sr: begin
                        ctrl.aluop = funct7[5] ? alu_sra : alu_srl;
                    end
                    slt, sltu: begin
                        ctrl.cmpmux_sel     = (opcode == op_imm) ? cmpmux_i_imm
                                                                 : cmpmux_rs2_out;
                        ctrl.cmpop          = (arith_funct3 == slt) ? blt : bltu;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    add: begin
                        // addi has no sub form, funct7 is immediate bits there
                        if (opcode == op_reg && funct7[5]) begin
                            ctrl.aluop = alu_sub;
                        end else begin
                            ctrl.aluop = alu_add;
                        end
                    end
                    default: begin
                        ctrl.aluop = alu_ops'(funct3);
                    end
                endcase
            end
            default: begin
                ctrl = '0; // invalid: no write, no memory access
            end
        endcase
    end

endmodule

// File: regfile.sv
module regfile
    import rv32i_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  wb_t               wr,
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_en;

    assign wr_en = wr.valid && wr.we; // we already excludes x0

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // same-cycle write shows through
    assign rs1_data = (wr_en && wr.rd == rs1) ? wr.data : regs[rs1];
    assign rs2_data = (wr_en && wr.rd == rs2) ? wr.data : regs[rs2];

endmodule

// File: decode_stage.sv
module decode_stage
    import rv32i_types_pkg::*;
(
    input  logic              instr_valid,
    input  logic [XLEN-1:0]   instr,
    input  logic [XLEN-1:0]   instr_pc,
    input  wb_t               ex_fwd,
    input  logic [XLEN-1:0]   rs1_data,
    input  logic [XLEN-1:0]   rs2_data,
    output logic [REG_AW-1:0] rs1,
    output logic [REG_AW-1:0] rs2,
    output id_ex_t            id_ex
);

    rv32i_control_word ctrl;
    logic              fwd_hit_rs1;
    logic              fwd_hit_rs2;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    control_rom u_control_rom (
        .opcode (rv32i_opcode'(instr[6:0])),
        .funct3 (instr[14:12]),
        .funct7 (instr[31:25]),
        .ctrl   (ctrl)
    );

    // result still in execute
    assign fwd_hit_rs1 = ex_fwd.valid && ex_fwd.we && ex_fwd.rd == rs1;
    assign fwd_hit_rs2 = ex_fwd.valid && ex_fwd.we && ex_fwd.rd == rs2;

    always_comb begin
        id_ex.valid   = instr_valid;
        id_ex.pc      = instr_pc;
        id_ex.ctrl    = ctrl;
        id_ex.rs1_val = fwd_hit_rs1 ? ex_fwd.data : rs1_data;
        id_ex.rs2_val = fwd_hit_rs2 ? ex_fwd.data : rs2_data;
        id_ex.rd      = instr[11:7];
        id_ex.i_imm   = {{21{instr[31]}}, instr[30:20]};
        id_ex.s_imm   = {{21{instr[31]}}, instr[30:25], instr[11:7]};
        id_ex.b_imm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        id_ex.u_imm   = {instr[31:12], 12'h000};
        id_ex.j_imm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    end

endmodule

// File: execute_stage.sv
module execute_stage
    import rv32i_types_pkg::*;
(
    input  id_ex_t          id_ex,
    input  logic [XLEN-1:0] mem_rdata,
    output mem_req_t        mem_req,
    output wb_t             wb
);

    rv32i_control_word ctrl;
    logic [XLEN-1:0]   alu_a, alu_b, alu_out, cmp_b, mem_addr, pc_plus4;
    logic [7:0]        load_byte;
    logic [15:0]       load_half;
    logic              br_en;

    assign ctrl     = id_ex.ctrl;
    assign pc_plus4 = id_ex.pc + 32'd4;

    always_comb begin
        alu_a = (ctrl.alumux1_sel == alumux1_pc_out) ? id_ex.pc : id_ex.rs1_val;
        case (ctrl.alumux2_sel)
            alumux2_u_imm:   alu_b = id_ex.u_imm;
            alumux2_b_imm:   alu_b = id_ex.b_imm;
            alumux2_s_imm:   alu_b = id_ex.s_imm;
            alumux2_j_imm:   alu_b = id_ex.j_imm;
            alumux2_rs2_out: alu_b = id_ex.rs2_val;
            default:         alu_b = id_ex.i_imm;
        endcase
        case (ctrl.aluop)
            alu_add: alu_out = alu_a + alu_b;
            alu_sll: alu_out = alu_a << alu_b[4:0];
            alu_sra: alu_out = $signed(alu_a) >>> alu_b[4:0];
            alu_sub: alu_out = alu_a - alu_b;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            alu_or:  alu_out = alu_a | alu_b;
            default: alu_out = alu_a & alu_b;
        endcase
    end

    assign cmp_b = (ctrl.cmpmux_sel == cmpmux_i_imm) ? id_ex.i_imm : id_ex.rs2_val;

    always_comb begin
        case (ctrl.cmpop)
            beq:     br_en = id_ex.rs1_val == cmp_b;
            bne:     br_en = id_ex.rs1_val != cmp_b;
            blt:     br_en = $signed(id_ex.rs1_val) < $signed(cmp_b);
            bge:     br_en = $signed(id_ex.rs1_val) >= $signed(cmp_b);
            bltu:    br_en = id_ex.rs1_val < cmp_b;
            default: br_en = id_ex.rs1_val >= cmp_b;
        endcase
    end

    assign mem_addr = (ctrl.marmux_sel == marmux_alu_out) ? alu_out : id_ex.pc;

    always_comb begin
        mem_req.read    = id_ex.valid && ctrl.mem_read;
        mem_req.write   = id_ex.valid && ctrl.mem_write;
        mem_req.addr    = mem_addr;
        mem_req.wdata   = id_ex.rs2_val;
        mem_req.byte_en = ctrl.mem_byte_en;
    end

    // pick the addressed lane of the returned word
    assign load_byte = mem_rdata[8*mem_addr[1:0] +: 8];
    assign load_half = mem_addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        wb.valid  = id_ex.valid;
        wb.we     = ctrl.load_regfile && id_ex.rd != '0;
        wb.rd     = id_ex.rd;
        wb.taken  = ctrl.pcmux_sel != pcmux_pc_plus4 || (ctrl.opcode == op_br && br_en);
        wb.target = (ctrl.pcmux_sel == pcmux_alu_mod2) ? {alu_out[XLEN-1:1], 1'b0} : alu_out;
        case (ctrl.regfilemux_sel)
            regfilemux_br_en:    wb.data = {{(XLEN-1){1'b0}}, br_en};
            regfilemux_u_imm:    wb.data = id_ex.u_imm;
            regfilemux_lw:       wb.data = mem_rdata;
            regfilemux_pc_plus4: wb.data = pc_plus4;
            regfilemux_lb:       wb.data = {{24{load_byte[7]}}, load_byte};
            regfilemux_lbu:      wb.data = {24'h0, load_byte};
            regfilemux_lh:       wb.data = {{16{load_half[15]}}, load_half};
            regfilemux_lhu:      wb.data = {16'h0, load_half};
            default:             wb.data = alu_out;
        endcase
    end

endmodule

// File: stage_reg.sv
module stage_reg
    import rv32i_types_pkg::*;
#(
    parameter type payload_t = wb_t
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0; // valid bit goes low with the rest
        end else begin
            q <= d;
        end
    end

endmodule

// File: rv32i_exec_core.sv
module rv32i_exec_core
    import rv32i_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  logic [XLEN-1:0] instr,
    input  logic [XLEN-1:0] instr_pc,
    input  logic [XLEN-1:0] mem_rdata,
    output mem_req_t        mem_req,
    output wb_t             wb
);

    id_ex_t            id_ex_d, id_ex_q;
    wb_t               wb_d, wb_q;
    logic [REG_AW-1:0] rs1, rs2;
    logic [XLEN-1:0]   rs1_data, rs2_data;

    decode_stage u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .ex_fwd      (wb_d),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1         (rs1),
        .rs2         (rs2),
        .id_ex       (id_ex_d)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex_reg (.clk(clk), .rst(rst), .d(id_ex_d), .q(id_ex_q));

    execute_stage u_execute (
        .id_ex     (id_ex_q),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .wb        (wb_d)
    );

    stage_reg #(.payload_t(wb_t)) u_wb_reg (.clk(clk), .rst(rst), .d(wb_d), .q(wb_q));

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .wr       (wb_q),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign wb = wb_q;

endmodule

// File: rv32i_exec_assert.sv
module rv32i_exec_assert
    import rv32i_types_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     instr_valid,
    input mem_req_t mem_req,
    input wb_t      wb
);

    // fixed latency, no stalls anywhere
    wb_latency: assert property (@(posedge clk) disable iff (rst)
        wb.valid == $past(instr_valid, 2))
        else $error("wb.valid does not follow instr_valid by two cycles");

    mem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write))
        else $error("mem_req.read and mem_req.write high together");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !wb.valid && !mem_req.read && !mem_req.write)
        else $error("outputs active in the first cycle after reset");

endmodule

bind rv32i_exec_core rv32i_exec_assert u_exec_assert (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .mem_req     (mem_req),
    .wb          (wb)
);

// File: tb_rv32i_exec.sv
module tb_rv32i_exec
    import rv32i_types_pkg::*;
();

    // one line of exec_input.txt
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rdata;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic [31:0] target;
        logic        mem_read;
        logic        mem_write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } vec_t;

    logic            clk;
    logic            rst;
    logic            instr_valid;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] instr_pc;
    logic [XLEN-1:0] mem_rdata;
    mem_req_t        mem_req;
    wb_t             wb;

    vec_t        vecs[$];
    vec_t        pending[$];  // issued, waiting for wb
    vec_t        in_exec;
    int          checked;
    bit          loaded = 1'b0;
    logic [31:0] rng;

    rv32i_exec_core dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .wb          (wb)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic is_control_flow(input logic [31:0] word);
        return word[6:0] == 7'h63 || word[6:0] == 7'h6f || word[6:0] == 7'h67;
    endfunction

    task automatic check(input string field, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %08h, expected %08h", $time, field, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [13];
        vec_t        v;
        fd = $fopen("exec_input.txt", "r");
        if (fd == 0) begin
            $display("could not open exec_input.txt");
            $display("SOME TESTS FAILED");
            $fatal(1, "no stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                f[7], f[8], f[9], f[10], f[11], f[12]);
                    if (n != 13) begin
                        $display("malformed line in exec_input.txt: %s", line);
                        $display("SOME TESTS FAILED");
                        $fatal(1, "bad stimulus line");
                    end else begin
                        v.instr     = f[0];
                        v.pc        = f[1];
                        v.rdata     = f[2];
                        v.we        = f[3][0];
                        v.rd        = f[4][4:0];
                        v.data      = f[5];
                        v.taken     = f[6][0];
                        v.target    = f[7];
                        v.mem_read  = f[8][0];
                        v.mem_write = f[9][0];
                        v.addr      = f[10];
                        v.wdata     = f[11];
                        v.byte_en   = f[12][3:0];
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one clock: check the instruction now in execute, then drive the next one
    task automatic step_cycle(input logic valid, input vec_t v);
        @(posedge clk);
        #10;
        check("mem_req.read", 32'(mem_req.read), 32'(in_exec.mem_read));
        check("mem_req.write", 32'(mem_req.write), 32'(in_exec.mem_write));
        if (in_exec.mem_read || in_exec.mem_write) begin
            check("mem_req.addr", mem_req.addr, in_exec.addr);
            check("mem_req.byte_en", 32'(mem_req.byte_en), 32'(in_exec.byte_en));
        end
        if (in_exec.mem_write) begin
            check("mem_req.wdata", mem_req.wdata, in_exec.wdata);
        end
        if (mem_req.read) begin
            mem_rdata = in_exec.rdata; // zero wait state reply
        end else begin
            rng = xorshift32(rng);
            mem_rdata = rng;
        end
        instr_valid = valid;
        instr = v.instr;
        instr_pc = v.pc;
        if (valid) begin
            in_exec = v;
            pending.push_back(v);
        end else begin
            in_exec = '0;
        end
    endtask

    always @(negedge clk) begin
        vec_t e;
        if (!rst && wb.valid) begin
            if (pending.size() == 0) begin
                $display("wb.valid pulsed with no instruction outstanding");
                $display("SOME TESTS FAILED");
                $fatal(1, "unexpected writeback");
            end else begin
                e = pending.pop_front();
                check("wb.we", 32'(wb.we), 32'(e.we));
                check("wb.taken", 32'(wb.taken), 32'(e.taken));
                if (e.we) begin
                    check("wb.rd", 32'(wb.rd), 32'(e.rd));
                    check("wb.data", wb.data, e.data);
                end
                if (is_control_flow(e.instr)) begin
                    check("wb.target", wb.target, e.target);
                end
                checked++;
            end
        end
    end

    initial begin
        int   idle;
        vec_t blank;
        clk = 1'b0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        instr_pc = '0;
        mem_rdata = '0;
        rng = 32'ha00a;
        checked = 0;
        in_exec = '0;
        blank = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        foreach (vecs[i]) begin
            step_cycle(1'b1, vecs[i]);
            rng = xorshift32(rng);
            idle = int'(rng[1:0]); // 0 to 3 bubbles
            repeat (idle) step_cycle(1'b0, vecs[i]);
        end
        while (pending.size() != 0) begin
            step_cycle(1'b0, blank);
        end
        if (vecs.size() > 0 && checked == vecs.size()) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d results were seen", checked, vecs.size());
            $display("SOME TESTS FAILED");
            $fatal(1, "incomplete run");
        end
    end

    // budget of five cycles per line
    initial begin
        wait (loaded);
        repeat (vecs.size() * 5 + 50) @(posedge clk);
        $display("timed out before all results came back");
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: exec_input.txt
# instr pc mem_rdata | expected: we rd data taken target mem_read mem_write addr wdata byte_en
# all hex; fields that do not apply to an instruction are zero
7ff00093 00000100 00000000 1 01 000007ff 0 00000000 0 0 00000000 00000000 0
00409113 00000104 00000000 1 02 00007ff0 0 00000000 0 0 00000000 00000000 0
800001b7 00000108 00000000 1 03 80000000 0 00000000 0 0 00000000 00000000 0
4041d213 0000010c 00000000 1 04 f8000000 0 00000000 0 0 00000000 00000000 0
fff24293 00000110 00000000 1 05 07ffffff 0 00000000 0 0 00000000 00000000 0
00228333 00000114 00000000 1 06 08007fef 0 00000000 0 0 00000000 00000000 0
401103b3 00000118 00000000 1 07 000077f1 0 00000000 0 0 00000000 00000000 0
00139433 0000011c 00000000 1 08 80000000 0 00000000 0 0 00000000 00000000 0
402454b3 00000120 00000000 1 09 ffff8000 0 00000000 0 0 00000000 00000000 0
12345517 00000124 00000000 1 0a 12345124 0 00000000 0 0 00000000 00000000 0
edc50593 00000128 00000000 1 0b 12345000 0 00000000 0 0 00000000 00000000 0
00522633 0000012c 00000000 1 0c 00000001 0 00000000 0 0 00000000 00000000 0
005236b3 00000130 00000000 1 0d 00000000 0 00000000 0 0 00000000 00000000 0
00122713 00000134 00000000 1 0e 00000001 0 00000000 0 0 00000000 00000000 0
fff2b793 00000138 00000000 1 0f 00000001 0 00000000 0 0 00000000 00000000 0
00e60463 0000013c 00000000 0 00 00000000 1 00000144 0 0 00000000 00000000 0
fee618e3 00000140 00000000 0 00 00000000 0 00000130 0 0 00000000 00000000 0
00524663 00000144 00000000 0 00 00000000 1 00000150 0 0 00000000 00000000 0
00525663 00000148 00000000 0 00 00000000 0 00000154 0 0 00000000 00000000 0
00526863 0000014c 00000000 0 00 00000000 0 0000015c 0 0 00000000 00000000 0
005270e3 00000150 00000000 0 00 00000000 1 00000950 0 0 00000000 00000000 0
1000086f 00000154 00000000 1 10 00000158 1 00000254 0 0 00000000 00000000 0
011808e7 00000158 00000000 1 11 0000015c 1 00000168 0 0 00000000 00000000 0
009581a3 0000015c 00000000 0 00 00000000 0 00000000 0 1 12345003 ffff8000 1
fe659f23 00000160 00000000 0 00 00000000 0 00000000 0 1 12344ffe 08007fef 3
04702023 00000164 00000000 0 00 00000000 0 00000000 0 1 00000040 000077f1 f
00158903 00000168 8899aabb 1 12 ffffffaa 0 00000000 1 0 12345001 00000000 f
0035c983 0000016c 8899aabb 1 13 00000088 0 00000000 1 0 12345003 00000000 f
00259a03 00000170 8899aabb 1 14 ffff8899 0 00000000 1 0 12345002 00000000 f
0005da83 00000174 1234f00d 1 15 0000f00d 0 00000000 1 0 12345000 00000000 f
0045ab03 00000178 cafef00d 1 16 cafef00d 0 00000000 1 0 12345004 00000000 f
012b0bb3 0000017c 00000000 1 17 cafeefb7 0 00000000 0 0 00000000 00000000 0
00508013 00000180 00000000 0 00 00000000 0 00000000 0 0 00000000 00000000 0
00000c33 00000184 00000000 1 18 00000000 0 00000000 0 0 00000000 00000000 0
0000000f 00000188 00000000 0 00 00000000 0 00000000 0 0 00000000 00000000 0

// File: filelist.f
rv32i_types_pkg.sv
control_rom.sv
regfile.sv
decode_stage.sv
execute_stage.sv
stage_reg.sv
rv32i_exec_core.sv
rv32i_exec_assert.sv
tb_rv32i_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_rv32i_exec \
    -f filelist.f \
    -o sim_tb
./obj_dir/sim_tb
